// File: source/bp_pkg.sv
package bp_pkg;

    // Width of a PC and of a branch target.
    parameter int XLEN = 32;

    // Two-bit saturating direction counter, ordered from strongly not taken
    // up to strongly taken so that a compare against WEAK_T gives the decision.
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } counter_t;

    // States of the four-phase commit receiver.
    typedef enum logic {
        PORT_IDLE = 1'b0,
        PORT_ACK  = 1'b1
    } port_state_t;

    // A resolved branch as reported by the reorder buffer.
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic            taken;
        logic [XLEN-1:0] target;
    } commit_info_t;

    // Result handed back to fetch in the same cycle as the lookup.
    typedef struct packed {
        logic            taken;
        logic            hit;
        logic [XLEN-1:0] next_pc;
    } prediction_t;

    // Counter value held by every table entry after reset.
    parameter counter_t COUNTER_RESET = WEAK_NT;

    // Saturating step of a direction counter toward the resolved outcome.
    function automatic counter_t counter_step(counter_t state, logic taken);
        counter_t next_state;
        next_state = state;
        if (taken) begin
            case (state)
                STRONG_NT: next_state = WEAK_NT;
                WEAK_NT:   next_state = WEAK_T;
                WEAK_T:    next_state = STRONG_T;
                default:   next_state = STRONG_T;
            endcase
        end else begin
            case (state)
                STRONG_T:  next_state = WEAK_T;
                WEAK_T:    next_state = WEAK_NT;
                WEAK_NT:   next_state = STRONG_NT;
                default:   next_state = STRONG_NT;
            endcase
        end
        return next_state;
    endfunction

endpackage

// File: source/pattern_history_table.sv
module pattern_history_table
    import bp_pkg::*;
#(
    parameter int PHT_INDEX_BITS = 6
) (
    input  logic                      clk,
    input  logic                      reset,

    input  logic [PHT_INDEX_BITS-1:0] read_index,
    output counter_t                  read_state,

    input  logic                      train_valid,
    input  logic [PHT_INDEX_BITS-1:0] train_index,
    input  logic                      train_taken
);

    localparam int PHT_SIZE = 1 << PHT_INDEX_BITS;

    counter_t counters [PHT_SIZE];
    counter_t train_state;
    counter_t train_next;

    // Lookup is purely combinational so fetch gets its answer this cycle.
    assign read_state = counters[read_index];

    // Current and stepped value of the entry being trained.
    assign train_state = counters[train_index];
    assign train_next  = counter_step(train_state, train_taken);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PHT_SIZE; i++) begin
                counters[i] <= COUNTER_RESET;
            end
        end else if (train_valid) begin
            counters[train_index] <= train_next;
        end
    end

endmodule

// File: source/branch_target_buffer.sv
module branch_target_buffer
    import bp_pkg::*;
#(
    parameter int BTB_INDEX_BITS = 4
) (
    input  logic            clk,
    input  logic            reset,

    input  logic [XLEN-1:0] lookup_pc,
    output logic            hit,
    output logic [XLEN-1:0] target,

    input  logic            write_en,
    input  logic [XLEN-1:0] write_pc,
    input  logic [XLEN-1:0] write_target
);

    localparam int BTB_SIZE = 1 << BTB_INDEX_BITS;

    // The two low PC bits are always zero and the index sits right above them,
    // so the tag is whatever is left at the top.
    localparam int TAG_BITS = XLEN - BTB_INDEX_BITS - 2;

    typedef struct packed {
        logic                valid;
        logic [TAG_BITS-1:0] tag;
        logic [XLEN-1:0]     target;
    } btb_entry_t;

    btb_entry_t entries [BTB_SIZE];

    logic [BTB_INDEX_BITS-1:0] lookup_index;
    logic [TAG_BITS-1:0]       lookup_tag;
    logic [BTB_INDEX_BITS-1:0] write_index;
    logic [TAG_BITS-1:0]       write_tag;
    btb_entry_t                lookup_entry;

    assign lookup_index = lookup_pc[BTB_INDEX_BITS+1:2];
    assign lookup_tag   = lookup_pc[XLEN-1:BTB_INDEX_BITS+2];
    assign write_index  = write_pc[BTB_INDEX_BITS+1:2];
    assign write_tag    = write_pc[XLEN-1:BTB_INDEX_BITS+2];

    assign lookup_entry = entries[lookup_index];
    assign hit          = lookup_entry.valid && (lookup_entry.tag == lookup_tag);
    assign target       = lookup_entry.target;

    // Only the valid bits are cleared; tag and target are don't-care until
    // the first write of an entry.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BTB_SIZE; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (write_en) begin
            // Direct mapped, so a write always evicts whatever was there.
            entries[write_index] <= '{valid: 1'b1, tag: write_tag, target: write_target};
        end
    end

endmodule

// File: source/commit_update_port.sv
module commit_update_port
    import bp_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    // Four-phase handshake with the reorder buffer.
    input  logic         commit_req,
    input  commit_info_t commit_info,
    output logic         commit_ack,

    // One-cycle training request toward the predictor tables.
    output logic         train_valid,
    output commit_info_t train_info
);

    port_state_t  state;
    port_state_t  state_next;
    logic         capture;
    commit_info_t info_q;
    logic         train_valid_q;

    // A record is taken only when a new request shows up while idle, which
    // gives exactly one training pulse per transfer no matter how long the
    // request is held.
    assign capture = (state == PORT_IDLE) && commit_req;

    always_comb begin
        state_next = state;
        case (state)
            PORT_IDLE: begin
                if (commit_req) begin
                    state_next = PORT_ACK;
                end
            end
            PORT_ACK: begin
                // Wait for the sender to withdraw before closing the transfer.
                if (!commit_req) begin
                    state_next = PORT_IDLE;
                end
            end
            default: begin
                state_next = PORT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= PORT_IDLE;
            train_valid_q <= 1'b0;
        end else begin
            state         <= state_next;
            train_valid_q <= capture;
        end
    end

    // Payload register.
    always_ff @(posedge clk) begin
        if (capture) begin
            info_q <= commit_info;
        end
    end

    assign commit_ack  = (state == PORT_ACK);
    assign train_valid = train_valid_q;
    assign train_info  = info_q;

endmodule

// File: source/branch_predictor.sv
module branch_predictor
    import bp_pkg::*;
#(
    parameter int PHT_INDEX_BITS = 6,
    parameter int BTB_INDEX_BITS = 4
) (
    input  logic            clk,
    input  logic            reset,

    input  logic [XLEN-1:0] fetch_pc,
    output prediction_t     prediction,

    input  logic            train_valid,
    input  commit_info_t    train_info
);

    logic [PHT_INDEX_BITS-1:0] pht_read_index;
    logic [PHT_INDEX_BITS-1:0] pht_train_index;
    counter_t                  pht_state;

    logic                      btb_hit;
    logic [XLEN-1:0]           btb_target;
    logic                      btb_write_en;

    logic                      predict_taken;

    // Counters are indexed by word address, ignoring the byte offset.
    assign pht_read_index  = fetch_pc[PHT_INDEX_BITS+1:2];
    assign pht_train_index = train_info.pc[PHT_INDEX_BITS+1:2];

    // Only taken branches carry a target worth remembering.
    assign btb_write_en = train_valid && train_info.taken;

    pattern_history_table #(
        .PHT_INDEX_BITS(PHT_INDEX_BITS)
    ) pattern_history_table_inst (
        .clk         (clk),
        .reset       (reset),
        .read_index  (pht_read_index),
        .read_state  (pht_state),
        .train_valid (train_valid),
        .train_index (pht_train_index),
        .train_taken (train_info.taken)
    );

    branch_target_buffer #(
        .BTB_INDEX_BITS(BTB_INDEX_BITS)
    ) branch_target_buffer_inst (
        .clk          (clk),
        .reset        (reset),
        .lookup_pc    (fetch_pc),
        .hit          (btb_hit),
        .target       (btb_target),
        .write_en     (btb_write_en),
        .write_pc     (train_info.pc),
        .write_target (train_info.target)
    );

    assign predict_taken = (pht_state >= WEAK_T);

    // Redirect only when the direction says taken and we actually know where to.
    always_comb begin
        prediction.taken = predict_taken;
        prediction.hit   = btb_hit;
        if (predict_taken && btb_hit) begin
            prediction.next_pc = btb_target;
        end else begin
            prediction.next_pc = fetch_pc + XLEN'(4);
        end
    end

endmodule

// File: source/branch_predictor_top.sv
module branch_predictor_top
    import bp_pkg::*;
#(
    parameter int PHT_INDEX_BITS = 6,
    parameter int BTB_INDEX_BITS = 4
) (
    input  logic            clk,
    input  logic            reset,

    input  logic [XLEN-1:0] fetch_pc,
    output prediction_t     prediction,

    input  logic            commit_req,
    input  commit_info_t    commit_info,
    output logic            commit_ack
);

    logic         train_valid;
    commit_info_t train_info;

    commit_update_port commit_update_port_inst (
        .clk         (clk),
        .reset       (reset),
        .commit_req  (commit_req),
        .commit_info (commit_info),
        .commit_ack  (commit_ack),
        .train_valid (train_valid),
        .train_info  (train_info)
    );

    branch_predictor #(
        .PHT_INDEX_BITS(PHT_INDEX_BITS),
        .BTB_INDEX_BITS(BTB_INDEX_BITS)
    ) branch_predictor_inst (
        .clk         (clk),
        .reset       (reset),
        .fetch_pc    (fetch_pc),
        .prediction  (prediction),
        .train_valid (train_valid),
        .train_info  (train_info)
    );

endmodule

// File: tests/branch_predictor_sva.sv
module commit_port_checker (
    input logic clk,
    input logic reset,
    input logic commit_req,
    input logic commit_ack,
    input logic train_valid
);

    // An acknowledge is only legal while answering a request seen at the
    // previous edge, including the one cycle it lingers after the drop.
    ack_follows_req: assert property (
        @(posedge clk) disable iff (reset)
        commit_ack |-> $past(commit_req)
    ) else $error("commit_ack is high without a prior commit_req");

    // Each transfer trains the tables exactly once.
    train_pulse_single: assert property (
        @(posedge clk) disable iff (reset)
        train_valid |=> !train_valid
    ) else $error("train_valid lasted longer than one cycle");

    reset_clears_port: assert property (
        @(posedge clk)
        reset |=> (!commit_ack && !train_valid)
    ) else $error("commit_ack or train_valid high after reset");

endmodule

bind commit_update_port commit_port_checker commit_port_checker_inst (
    .clk         (clk),
    .reset       (reset),
    .commit_req  (commit_req),
    .commit_ack  (commit_ack),
    .train_valid (train_valid)
);

// File: tests/branch_predictor_tb.sv
module branch_predictor_tb
    import bp_pkg::*;
();

    localparam int PHT_BITS = 6;
    localparam int BTB_BITS = 4;
    localparam int PHT_SIZE = 1 << PHT_BITS;
    localparam int BTB_SIZE = 1 << BTB_BITS;
    localparam int TAG_BITS = XLEN - BTB_BITS - 2;

    localparam int POOL_SIZE       = 8;
    localparam int RANDOM_COMMITS  = 200;
    localparam int DIRECTED_STEPS  = 40;
    localparam int ACK_WAIT_LIMIT  = 16;
    // A commit followed by its prediction check takes at most about eight cycles.
    localparam int CYCLES_PER_STEP = 8;
    localparam int TIMEOUT_CYCLES  = (RANDOM_COMMITS + DIRECTED_STEPS) * CYCLES_PER_STEP;

    logic            clk;
    logic            reset;
    logic [XLEN-1:0] fetch_pc;
    prediction_t     prediction;
    logic            commit_req;
    commit_info_t    commit_info;
    logic            commit_ack;

    integer seed;
    int     error_count;
    int     cycle_count;

    // Reference model of both tables.
    counter_t            model_counter [PHT_SIZE];
    logic                model_valid   [BTB_SIZE];
    logic [TAG_BITS-1:0] model_tag     [BTB_SIZE];
    logic [XLEN-1:0]     model_target  [BTB_SIZE];
    logic [XLEN-1:0]     pc_pool       [POOL_SIZE];

    branch_predictor_top branch_predictor_top_inst (
        .clk         (clk),
        .reset       (reset),
        .fetch_pc    (fetch_pc),
        .prediction  (prediction),
        .commit_req  (commit_req),
        .commit_info (commit_info),
        .commit_ack  (commit_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string line);
        error_count++;
        $display("%s", line);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic compare_prediction(input string name, input prediction_t expected,
                                      input prediction_t actual);
        if (actual !== expected) begin
            fail_run($sformatf(
                {"Error %s: expected taken=%0b hit=%0b next_pc=%h, ",
                 "actual taken=%0b hit=%0b next_pc=%h"},
                name, expected.taken, expected.hit, expected.next_pc,
                actual.taken, actual.hit, actual.next_pc));
        end
    endtask

    task automatic compare_ack(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("Error %s: expected commit_ack=%0b, actual commit_ack=%0b",
                               name, expected, actual));
        end
    endtask

    task automatic model_reset();
        for (int i = 0; i < PHT_SIZE; i++) begin
            model_counter[i] = WEAK_NT;
        end
        for (int i = 0; i < BTB_SIZE; i++) begin
            model_valid[i] = 1'b0;
        end
    endtask

    task automatic model_train(input commit_info_t info);
        counter_t c;
        c = model_counter[info.pc[PHT_BITS+1:2]];
        if (info.taken && c != STRONG_T) begin
            c = counter_t'(c + 2'd1);
        end else if (!info.taken && c != STRONG_NT) begin
            c = counter_t'(c - 2'd1);
        end
        model_counter[info.pc[PHT_BITS+1:2]] = c;
        if (info.taken) begin
            model_valid[info.pc[BTB_BITS+1:2]]  = 1'b1;
            model_tag[info.pc[BTB_BITS+1:2]]    = info.pc[XLEN-1:BTB_BITS+2];
            model_target[info.pc[BTB_BITS+1:2]] = info.target;
        end
    endtask

    function automatic prediction_t make_prediction(input logic taken, input logic hit,
                                                    input logic [XLEN-1:0] next_pc);
        prediction_t p;
        p.taken   = taken;
        p.hit     = hit;
        p.next_pc = next_pc;
        return p;
    endfunction

    function automatic prediction_t model_predict(input logic [XLEN-1:0] pc);
        counter_t        c;
        logic            taken;
        logic            hit;
        logic [XLEN-1:0] next_pc;
        c     = model_counter[pc[PHT_BITS+1:2]];
        taken = (c == WEAK_T) || (c == STRONG_T);
        hit   = model_valid[pc[BTB_BITS+1:2]] &&
                (model_tag[pc[BTB_BITS+1:2]] == pc[XLEN-1:BTB_BITS+2]);
        next_pc = (taken && hit) ? model_target[pc[BTB_BITS+1:2]] : pc + 32'd4;
        return make_prediction(taken, hit, next_pc);
    endfunction

    task automatic wait_ack(input string name, input logic level);
        int waited;
        waited = 0;
        @(negedge clk);
        while (commit_ack !== level) begin
            if (waited >= ACK_WAIT_LIMIT) begin
                fail_run($sformatf("%s: commit_ack never went to %0b", name, level));
            end else begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    // Four-phase transfer of one resolved branch, then the model learns it too.
    task automatic commit_branch(input string name, input logic [XLEN-1:0] pc,
                                 input logic taken, input logic [XLEN-1:0] target,
                                 input int hold);
        commit_info_t info;
        info = '{pc: pc, taken: taken, target: target};
        @(posedge clk);
        commit_req  <= 1'b1;
        commit_info <= info;
        wait_ack(name, 1'b1);
        repeat (hold) @(posedge clk);
        @(posedge clk);
        commit_req <= 1'b0;
        wait_ack(name, 1'b0);
        model_train(info);
    endtask

    task automatic check_predict(input string name, input logic [XLEN-1:0] pc,
                                 input prediction_t expected);
        @(posedge clk);
        fetch_pc <= pc;
        @(negedge clk);
        compare_prediction(name, expected, prediction);
    endtask

    task automatic test_reset_state();
        logic [XLEN-1:0] pc;
        @(negedge clk);
        compare_ack("reset ack", 1'b0, commit_ack);
        for (int i = 0; i < 8; i++) begin
            pc = 32'($random(seed)) & 32'hffff_fffc;
            check_predict("reset prediction", pc, make_prediction(1'b0, 1'b0, pc + 32'd4));
        end
    endtask

    task automatic test_train_taken();
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target;
        pc     = 32'h0000_1040;
        target = 32'h0000_8000;
        commit_branch("train taken 1", pc, 1'b1, target, 0);
        check_predict("train first taken", pc, make_prediction(1'b1, 1'b1, target));
        commit_branch("train taken 2", pc, 1'b1, target, 0);
        check_predict("train second taken", pc, make_prediction(1'b1, 1'b1, target));
        commit_branch("train taken 3", pc, 1'b1, target, 0);
        commit_branch("train taken 4", pc, 1'b1, target, 0);
        commit_branch("train not taken 1", pc, 1'b0, 32'h0, 0);
        check_predict("train saturated", pc, make_prediction(1'b1, 1'b1, target));
        commit_branch("train not taken 2", pc, 1'b0, 32'h0, 0);
        check_predict("train weak not taken", pc, make_prediction(1'b0, 1'b1, pc + 32'd4));
    endtask

    task automatic test_train_not_taken();
        logic [XLEN-1:0] pc;
        pc = 32'h0000_1040;
        for (int i = 0; i < 4; i++) begin
            commit_branch("not taken run", pc, 1'b0, 32'h0, 0);
        end
        check_predict("not taken floor", pc, make_prediction(1'b0, 1'b1, pc + 32'd4));
        // From the floor, one taken step must land on WEAK_NT and not wrap to taken.
        commit_branch("not taken recover", pc, 1'b1, 32'h0000_8000, 0);
        check_predict("not taken no wrap", pc, make_prediction(1'b0, 1'b1, pc + 32'd4));
    endtask

    task automatic test_aliasing();
        logic [XLEN-1:0] pc_a;
        logic [XLEN-1:0] pc_b;
        logic [XLEN-1:0] pc_c;
        pc_a = 32'h0000_1040;
        pc_b = 32'h0000_1080;
        pc_c = 32'h0000_1140;
        commit_branch("alias train a", pc_a, 1'b1, 32'h0000_8000, 0);
        commit_branch("alias evict", pc_b, 1'b1, 32'h0000_9000, 0);
        check_predict("alias evicted a", pc_a, make_prediction(1'b1, 1'b0, pc_a + 32'd4));
        check_predict("alias new owner", pc_b, make_prediction(1'b1, 1'b1, 32'h0000_9000));
        check_predict("alias shared counter", pc_c, make_prediction(1'b1, 1'b0, pc_c + 32'd4));
    endtask

    task automatic test_handshake();
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target;
        int              hold;
        commit_info_t    info;
        pc     = 32'h0000_2204;
        target = 32'h0000_5a00;
        hold   = 2 + ($unsigned($random(seed)) % 6);
        info   = '{pc: pc, taken: 1'b1, target: target};
        @(posedge clk);
        commit_req  <= 1'b1;
        commit_info <= info;
        @(negedge clk);
        compare_ack("handshake before sample", 1'b0, commit_ack);
        @(negedge clk);
        compare_ack("handshake ack rise", 1'b1, commit_ack);
        repeat (hold) begin
            @(negedge clk);
            compare_ack("handshake ack hold", 1'b1, commit_ack);
        end
        @(posedge clk);
        commit_req <= 1'b0;
        @(negedge clk);
        compare_ack("handshake ack after drop", 1'b1, commit_ack);
        @(negedge clk);
        compare_ack("handshake ack fall", 1'b0, commit_ack);
        model_train(info);
        check_predict("handshake one step", pc, make_prediction(1'b1, 1'b1, target));
        // A double training would have reached STRONG_T and still predict taken here.
        commit_branch("handshake step back", pc, 1'b0, 32'h0, 0);
        check_predict("handshake step back", pc, make_prediction(1'b0, 1'b1, pc + 32'd4));
    endtask

    task automatic test_random_sequence();
        logic [XLEN-1:0] target;
        logic            taken;
        int              pick;
        int              hold;
        for (int i = 0; i < POOL_SIZE; i++) begin
            pc_pool[i] = 32'($random(seed)) & 32'h0000_03fc;
        end
        for (int i = 0; i < RANDOM_COMMITS; i++) begin
            pick   = $unsigned($random(seed)) % POOL_SIZE;
            taken  = 1'($random(seed));
            target = 32'($random(seed)) & 32'hffff_fffc;
            hold   = $unsigned($random(seed)) % 2;
            commit_branch($sformatf("random commit %0d", i), pc_pool[pick], taken, target, hold);
            pick = $unsigned($random(seed)) % POOL_SIZE;
            check_predict($sformatf("random predict %0d", i), pc_pool[pick],
                          model_predict(pc_pool[pick]));
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        fail_run($sformatf("Timeout: the tests did not finish within %0d cycles",
                           TIMEOUT_CYCLES));
    end

    initial begin
        seed        = 32'h3b36;
        error_count = 0;
        reset       = 1'b1;
        fetch_pc    = '0;
        commit_req  = 1'b0;
        commit_info = '0;
        model_reset();
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        test_reset_state();
        test_train_taken();
        test_train_not_taken();
        test_aliasing();
        test_handshake();
        test_random_sequence();

        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: branch_predictor_top.f
source/bp_pkg.sv
source/pattern_history_table.sv
source/branch_target_buffer.sv
source/commit_update_port.sv
source/branch_predictor.sv
source/branch_predictor_top.sv
tests/branch_predictor_sva.sv
tests/branch_predictor_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module branch_predictor_tb \
    -f branch_predictor_top.f

status=0
./obj_dir/Vbranch_predictor_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log || [ "$status" -ne 0 ]; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
